// File: src.f
ein_pkg.sv
bus_interface.sv
header_decoder.sv
ack_generator.sv
ein_mod.sv
ein_int.sv
ein_clock_gen.sv
ein_checker.sv
ein_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ein_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: ein_tb.sv
`timescale 1ns/100ps

module ein_tb import ein_pkg::*; ();

	localparam logic [7:0] DEV_ADDR = 8'h65;
	localparam int FIFO_DEPTH = 16;
	localparam int SYMBOL_CYCLES = 4;
	localparam int REPLY_TIMEOUT = 20000;

	typedef logic [7:0] byte_q_t[$];
	typedef logic [2:0] toggle_q_t[$];             // Change masks {emo, edi, eci}

	logic        clk, reset, sl_arb_grant, sl_data_latch, emo, edi, eci;
	ma_bus_t     ma;
	sl_bus_t     sl;
	logic [31:0] lcg_state;
	logic [2:0]  last_lines;
	logic        watch_toggles, overflow_seen;
	string       test_name;
	toggle_q_t   exp_toggles;

	ein_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clk (.clk(clk), .reset(reset));

	ein_int #(.DEV_ADDR(DEV_ADDR), .FIFO_DEPTH(FIFO_DEPTH), .SYMBOL_CYCLES(SYMBOL_CYCLES)) u_dut (
		.clk(clk), .reset(reset), .ma(ma), .sl(sl),
		.sl_arb_grant(sl_arb_grant), .sl_data_latch(sl_data_latch),
		.emo(emo), .edi(edi), .eci(eci)
	);

	bind ein_int ein_checker u_checker (
		.clk(clk), .reset(reset), .sl(sl), .sl_data_latch(sl_data_latch),
		.emo(emo), .edi(edi), .eci(eci)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Data bits go MSB first and every byte ends on eci
	// Frames that are not fragments get one more eci at the end
	function automatic toggle_q_t ref_toggles(input byte_q_t payload, input logic fragment);
		toggle_q_t toggles;
		foreach (payload[i]) begin
			for (int b = 7; b >= 0; b--)
				toggles.push_back(payload[i][b] ? 3'b100 : 3'b010);
			toggles.push_back(3'b001);
		end
		if (!fragment)
			toggles.push_back(3'b001);
		return toggles;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_toggle(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp)
			report_failure($sformatf("Error %s: toggle expected %03b, actual %03b", name, exp, act));
	endtask

	task automatic compare_reply(input string name, input reply_code_e exp_code,
			input logic [7:0] exp_eid, input logic [7:0] act_code, input logic [7:0] act_eid);
		if (act_code !== exp_code || act_eid !== exp_eid)
			report_failure($sformatf("Error %s: reply expected %02h %02h, actual %02h %02h",
				name, exp_code, exp_eid, act_code, act_eid));
	endtask

	// Line edges seen at the falling edge, where the outputs are settled
	always @(negedge clk) begin
		logic [2:0] now_lines;
		now_lines = {emo, edi, eci};
		if (sl.overflow)
			overflow_seen = 1'b1;
		if (!reset && watch_toggles && now_lines != last_lines) begin
			if (exp_toggles.size() == 0)
				report_failure($sformatf("%s: a line toggled when none was expected", test_name));
			else
				compare_toggle(test_name, exp_toggles.pop_front(), now_lines ^ last_lines);
		end
		last_lines = now_lines;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and arbiter
	//////////////////////////////////////////////////////////////////////

	task automatic random_payload(input int count, output byte_q_t payload);
		payload = {};
		repeat (count) begin
			lcg_state = lcg_next(lcg_state);
			payload.push_back(lcg_state[23:16]);
		end
	endtask

	task automatic send_frame(input logic [7:0] addr, input logic [7:0] eid,
			input logic fragment, input byte_q_t payload);
		byte_q_t bytes;
		bytes = payload;
		bytes.push_front({7'd0, fragment});         // Flags byte
		bytes.push_front(eid);
		foreach (bytes[i]) begin
			ma = '{data: bytes[i], addr: addr, data_valid: 1'b1, frame_valid: 1'b1};
			@(negedge clk);
		end
		ma = '0;
		@(negedge clk);
	endtask

	task automatic serve_reply(input string name, input reply_code_e exp_code,
			input logic [7:0] exp_eid, input int hold_cycles);
		logic [7:0] got [2];
		int waited;
		waited = 0;
		while (!sl.arb_request) begin
			@(negedge clk);
			waited++;
			if (waited > REPLY_TIMEOUT)
				report_failure($sformatf("%s: the DUT never requested the slave bus", name));
		end
		repeat (hold_cycles) begin
			if (sl.data_valid)
				report_failure($sformatf("%s: reply data driven before the grant", name));
			@(negedge clk);
		end
		sl_arb_grant = 1'b1;
		for (int i = 0; i < 2; i++) begin
			waited = 0;
			while (!sl.data_valid) begin
				@(negedge clk);
				waited++;
				if (waited > 100)
					report_failure($sformatf("%s: reply byte %0d never became valid", name, i));
			end
			got[i] = sl.data;
			sl_data_latch = 1'b1;
			@(negedge clk);
			sl_data_latch = 1'b0;
		end
		sl_arb_grant = 1'b0;
		if (sl.arb_request)
			report_failure($sformatf("%s: request still raised after two bytes", name));
		compare_reply(name, exp_code, exp_eid, got[0], got[1]);
	endtask

	task automatic run_frame(input string name, input logic fragment, input int count,
			input int hold_cycles);
		byte_q_t payload;
		logic [7:0] eid;
		test_name = name;
		random_payload(count, payload);
		lcg_state = lcg_next(lcg_state);
		eid = lcg_state[23:16];
		exp_toggles = ref_toggles(payload, fragment);
		send_frame(DEV_ADDR, eid, fragment, payload);
		serve_reply(name, REPLY_ACK, eid, hold_cycles);
		if (exp_toggles.size() != 0)
			report_failure($sformatf("%s: %0d toggles never appeared", name, exp_toggles.size()));
	endtask

	initial begin
		byte_q_t payload;
		int waited;
		ma = '0;
		sl_arb_grant = 1'b0;
		sl_data_latch = 1'b0;
		lcg_state = 32'h6b0e;
		watch_toggles = 1'b1;
		overflow_seen = 1'b0;
		test_name = "reset";
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 50)
				report_failure("Reset was never released");
		end while (reset);
		if ({emo, edi, eci} !== 3'b000 || sl.arb_request !== 1'b0)
			report_failure("Lines or arbitration request not idle after reset");

		run_frame("non_fragment_ack", 1'b0, 3, 50);
		run_frame("fragment_ack", 1'b1, 3, 0);

		test_name = "other_address";
		random_payload(3, payload);
		send_frame(8'h42, 8'h11, 1'b0, payload);
		for (waited = 0; waited < 2000; waited++) begin
			if (sl.arb_request)
				report_failure("other_address: the DUT answered a frame for another address");
			@(negedge clk);
		end

		test_name = "overflow_nak";
		watch_toggles = 1'b0;                       // Surviving bytes are not predictable here
		overflow_seen = 1'b0;
		random_payload(FIFO_DEPTH + 4, payload);
		send_frame(DEV_ADDR, 8'h5a, 1'b0, payload);
		if (!overflow_seen)
			report_failure("overflow_nak: no overflow pulse for an overfull frame");
		serve_reply(test_name, REPLY_NAK, 8'h5a, 0);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: ein_checker.sv
`timescale 1ns/100ps

module ein_checker import ein_pkg::*; (
	input logic    clk,
	input logic    reset,
	input sl_bus_t sl,
	input logic    sl_data_latch,
	input logic    emo,
	input logic    edi,
	input logic    eci
);

	logic [1:0] latch_cnt;                          // Reply bytes taken during this request

	always_ff @(posedge clk) begin
		if (reset || !sl.arb_request)
			latch_cnt <= 2'd0;
		else if (sl_data_latch && sl.data_valid)
			latch_cnt <= latch_cnt + 2'd1;
	end

	one_line_toggles: assert property (@(posedge clk) disable iff (reset)
		$onehot0({emo, edi, eci} ^ $past({emo, edi, eci})))
		else $error("More than one of emo, edi and eci changed in one cycle");

	valid_needs_request: assert property (@(posedge clk) disable iff (reset)
		sl.data_valid |-> sl.arb_request)
		else $error("Slave data valid without an arbitration request");

	// The request may only drop right after the second byte was latched
	request_held: assert property (@(posedge clk) disable iff (reset)
		$fell(sl.arb_request) |-> $past(sl_data_latch && sl.data_valid && latch_cnt == 2'd1))
		else $error("Arbitration request dropped before the second byte was latched");

endmodule

// File: ein_clock_gen.sv
`timescale 1ns/100ps

module ein_clock_gen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;                               // Release away from the active edge
	end

endmodule

// File: ein_int.sv
`timescale 1ns/100ps

module ein_int import ein_pkg::*; #(
	parameter logic [7:0] DEV_ADDR = 8'h65,
	parameter int FIFO_DEPTH = 16,
	parameter int SYMBOL_CYCLES = 4000
) (
	input  logic    clk,
	input  logic    reset,
	input  ma_bus_t ma,
	output sl_bus_t sl,
	input  logic    sl_arb_grant,
	input  logic    sl_data_latch,
	output logic    emo,
	output logic    edi,
	output logic    eci
);

	frame_byte_t in_byte, reply_byte;
	hdr_info_t   hdr;
	ctrl_state_e state, next_state;
	logic        in_frame_active, frame_lost, hd_latch, mod_latch;
	logic        header_done, tx_busy, generate_reply, reply_active, reply_latch;

	//////////////////////////////////////////////////////////////////////
	// Datapath blocks
	//////////////////////////////////////////////////////////////////////

	bus_interface #(.DEV_ADDR(DEV_ADDR), .FIFO_DEPTH(FIFO_DEPTH)) u_bus (
		.clk(clk), .reset(reset),
		.ma(ma), .sl(sl),
		.sl_arb_grant(sl_arb_grant), .sl_data_latch(sl_data_latch),
		.in_byte(in_byte), .in_frame_active(in_frame_active),
		.in_latch(hd_latch | mod_latch),           // Header pops always come first
		.frame_lost(frame_lost),
		.reply_byte(reply_byte), .reply_active(reply_active), .reply_latch(reply_latch)
	);

	header_decoder u_hdr (
		.clk(clk), .reset(reset),
		.in_byte(in_byte), .in_frame_active(in_frame_active),
		.latch(hd_latch), .hdr(hdr), .header_done(header_done)
	);

	ack_generator u_ack (
		.clk(clk), .reset(reset),
		.generate_reply(generate_reply), .nak(frame_lost), .eid(hdr.eid),
		.reply_byte(reply_byte), .reply_active(reply_active), .reply_latch(reply_latch)
	);

	ein_mod #(.SYMBOL_CYCLES(SYMBOL_CYCLES)) u_mod (
		.clk(clk), .reset(reset),
		.in_byte(in_byte), .in_frame_active(in_frame_active),
		.fragment(hdr.fragment), .start_tx(header_done),
		.latch(mod_latch), .tx_busy(tx_busy),
		.emo(emo), .edi(edi), .eci(eci)
	);

	//////////////////////////////////////////////////////////////////////
	// Control FSM that sequences transmit and reply
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			CTRL_IDLE:     if (header_done) next_state = CTRL_TRANSMIT;
			CTRL_TRANSMIT: if (!in_frame_active && !tx_busy) next_state = CTRL_ACK;
			CTRL_ACK:      next_state = CTRL_IDLE;      // Single cycle that fires the reply
			default:       next_state = CTRL_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= CTRL_IDLE;
		else
			state <= next_state;
	end

	assign generate_reply = (state == CTRL_ACK);

endmodule

// File: ein_mod.sv
`timescale 1ns/100ps

module ein_mod import ein_pkg::*; #(
	parameter int SYMBOL_CYCLES = 4000
) (
	input  logic        clk,
	input  logic        reset,
	input  frame_byte_t in_byte,
	input  logic        in_frame_active,
	input  logic        fragment,
	input  logic        start_tx,
	output logic        latch,
	output logic        tx_busy,
	output logic        emo,
	output logic        edi,
	output logic        eci
);

	localparam int CW = $clog2(SYMBOL_CYCLES + 1);
	localparam logic [CW-1:0] LAST = CW'(SYMBOL_CYCLES - 1);

	mod_state_e    state;
	logic [CW-1:0] cnt;                             // Cycles spent in the current period
	logic [2:0]    bit_idx;
	logic [7:0]    shreg;
	logic          final_sep;                       // Separator closes the frame
	logic          period_end;

	assign period_end = (cnt == LAST);
	assign latch = (state == MOD_FETCH) && in_byte.valid;
	assign tx_busy = (state != MOD_IDLE);

	always_ff @(posedge clk) begin
		if (latch)
			shreg <= in_byte.data;
		else if (state == MOD_BIT && period_end)
			shreg <= {shreg[6:0], 1'b0};           // MSB first
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= MOD_IDLE;
			cnt <= '0;
			bit_idx <= 3'd0;
			final_sep <= 1'b0;
			emo <= 1'b0;
			edi <= 1'b0;
			eci <= 1'b0;
		end else begin
			case (state)
				MOD_IDLE: begin
					final_sep <= 1'b0;
					if (start_tx)
						state <= MOD_FETCH;
				end
				MOD_FETCH: begin
					if (in_byte.valid) begin
						state <= MOD_BIT;
						bit_idx <= 3'd7;
					end else if (!in_frame_active) begin
						if (fragment) begin
							state <= MOD_IDLE;      // Fragments end without a marker
						end else begin
							state <= MOD_SEP;
							final_sep <= 1'b1;
						end
					end
				end
				MOD_BIT: begin
					if (cnt == '0) begin
						if (shreg[7])
							emo <= ~emo;
						else
							edi <= ~edi;
					end
					if (period_end) begin
						cnt <= '0;
						if (bit_idx == 3'd0)
							state <= MOD_SEP;
						else
							bit_idx <= bit_idx - 3'd1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				MOD_SEP: begin
					if (cnt == '0)
						eci <= ~eci;
					if (period_end) begin
						cnt <= '0;
						state <= final_sep ? MOD_IDLE : MOD_FETCH;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= MOD_IDLE;
			endcase
		end
	end

endmodule

// File: ack_generator.sv
`timescale 1ns/100ps

module ack_generator import ein_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        generate_reply,
	input  logic        nak,
	input  logic [7:0]  eid,
	output frame_byte_t reply_byte,
	output logic        reply_active,
	input  logic        reply_latch
);

	reply_code_e code;
	logic [7:0]  eid_q;
	logic        byte_idx;                          // 0 is the code, 1 is the endpoint id

	always_ff @(posedge clk) begin
		if (generate_reply) begin
			code <= nak ? REPLY_NAK : REPLY_ACK;
			eid_q <= eid;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reply_active <= 1'b0;
			byte_idx <= 1'b0;
		end else if (generate_reply) begin
			reply_active <= 1'b1;
			byte_idx <= 1'b0;
		end else if (reply_active && reply_latch) begin
			if (byte_idx)
				reply_active <= 1'b0;               // Second byte taken, message done
			else
				byte_idx <= 1'b1;
		end
	end

	assign reply_byte.data = byte_idx ? eid_q : code;
	assign reply_byte.valid = reply_active;

endmodule

// File: header_decoder.sv
`timescale 1ns/100ps

module header_decoder import ein_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  frame_byte_t in_byte,
	input  logic        in_frame_active,
	output logic        latch,
	output hdr_info_t   hdr,
	output logic        header_done
);

	logic [1:0] hdr_cnt;                            // Header bytes taken in this frame

	// Only the first two bytes of a frame belong to the header
	assign latch = in_frame_active && in_byte.valid && (hdr_cnt < 2'd2);

	always_ff @(posedge clk) begin
		if (reset) begin
			hdr_cnt <= 2'd0;
			header_done <= 1'b0;
		end else begin
			header_done <= latch && (hdr_cnt == 2'd1);
			if (!in_frame_active)
				hdr_cnt <= 2'd0;                    // Frame gone, wait for the next one
			else if (latch)
				hdr_cnt <= hdr_cnt + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (latch && hdr_cnt == 2'd0)
			hdr.eid <= in_byte.data;
		if (latch && hdr_cnt == 2'd1)
			hdr.fragment <= in_byte.data[0];        // Rest of the flags byte is ignored
	end

endmodule

// File: bus_interface.sv
`timescale 1ns/100ps

module bus_interface import ein_pkg::*; #(
	parameter logic [7:0] DEV_ADDR = 8'h65,
	parameter int FIFO_DEPTH = 16
) (
	input  logic        clk,
	input  logic        reset,
	input  ma_bus_t     ma,
	output sl_bus_t     sl,
	input  logic        sl_arb_grant,
	input  logic        sl_data_latch,
	output frame_byte_t in_byte,
	output logic        in_frame_active,
	input  logic        in_latch,
	output logic        frame_lost,
	input  frame_byte_t reply_byte,
	input  logic        reply_active,
	output logic        reply_latch
);

	localparam int AW = $clog2(FIFO_DEPTH);

	typedef enum logic {SL_WAIT, SL_SEND} sl_state_e;

	logic [7:0]  mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr, rd_ptr;
	logic        fifo_empty, fifo_full, hit;
	logic        frame_valid_d, frame_start, frame_open, overflow_q;
	sl_state_e   sl_state;

	//////////////////////////////////////////////////////////////////////
	// Master side: address filter and input FIFO
	//////////////////////////////////////////////////////////////////////

	assign hit = ma.frame_valid && ma.data_valid && (ma.addr == DEV_ADDR);
	assign frame_start = ma.frame_valid && !frame_valid_d;
	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	always_ff @(posedge clk) begin
		if (hit && !fifo_full)
			mem[wr_ptr[AW-1:0]] <= ma.data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			frame_valid_d <= 1'b0;
			frame_open <= 1'b0;
			frame_lost <= 1'b0;
			overflow_q <= 1'b0;
		end else begin
			frame_valid_d <= ma.frame_valid;
			overflow_q <= hit && fifo_full;         // Dropped byte shows for one cycle
			if (hit && !fifo_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (in_latch && !fifo_empty)
				rd_ptr <= rd_ptr + 1'b1;
			if (hit)
				frame_open <= 1'b1;
			else if (!ma.frame_valid)
				frame_open <= 1'b0;
			if (frame_start)
				frame_lost <= 1'b0;                 // Lost flag belongs to one frame only
			if (hit && fifo_full)
				frame_lost <= 1'b1;
		end
	end

	assign in_byte.data = mem[rd_ptr[AW-1:0]];
	assign in_byte.valid = !fifo_empty;
	assign in_frame_active = frame_open || !fifo_empty;

	//////////////////////////////////////////////////////////////////////
	// Slave side: arbitration and reply bytes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			sl_state <= SL_WAIT;
		else if (sl_state == SL_WAIT && reply_active && sl_arb_grant)
			sl_state <= SL_SEND;
		else if (sl_state == SL_SEND && !reply_active)
			sl_state <= SL_WAIT;                    // Reply finished so the bus goes back
	end

	assign sl.arb_request = reply_active;
	assign sl.data_valid = (sl_state == SL_SEND) && reply_byte.valid;
	assign sl.data = reply_byte.data;
	assign sl.overflow = overflow_q;
	assign reply_latch = sl.data_valid && sl_data_latch;

endmodule

// File: ein_pkg.sv
package ein_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus records
	//////////////////////////////////////////////////////////////////////

	// One master-bus cycle as driven by the bus master
	typedef struct packed {
		logic [7:0] data;
		logic [7:0] addr;
		logic       data_valid;                     // Byte present this cycle
		logic       frame_valid;                    // High for the whole frame
	} ma_bus_t;

	// Everything this device drives onto the slave bus
	typedef struct packed {
		logic [7:0] data;
		logic       data_valid;
		logic       arb_request;
		logic       overflow;                       // One-cycle pulse per dropped byte
	} sl_bus_t;

	// A byte offered by a producer together with its valid flag
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
	} frame_byte_t;

	// Decoded frame header
	typedef struct packed {
		logic [7:0] eid;                            // Endpoint id, first header byte
		logic       fragment;                       // Bit 0 of the flags byte
	} hdr_info_t;

	//////////////////////////////////////////////////////////////////////
	// Codes and states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [7:0] {
		REPLY_ACK = 8'h06,
		REPLY_NAK = 8'h15
	} reply_code_e;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_TRANSMIT,
		CTRL_ACK
	} ctrl_state_e;

	typedef enum logic [1:0] {
		MOD_IDLE,
		MOD_FETCH,                                  // Pop the next payload byte
		MOD_BIT,                                    // One data bit on emo or edi
		MOD_SEP                                     // Byte or frame separator on eci
	} mod_state_e;

endpackage
